/* logic/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`default_nettype none

// Address of the first fetch after reset
`define RESET_PC 32'h0000_0000

// Width of the retire sequence counter
`define RETIRE_COUNT_W 16

// Architectural integer registers, x0 included
`define REG_COUNT 32

`default_nettype wire

`endif

/* logic/rv_pkg.sv */
`include "rv_settings.svh"

`default_nettype none

package rv_pkg;

    // Major opcode values match the RV32I opcode field
    typedef enum logic [6:0] {
        OPC_ILLEGAL = 7'b0000000,
        OPC_OP      = 7'b0110011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_BRANCH  = 7'b1100011,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_LUI     = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_PASS_B
    } aluOp_e;

    // Values follow funct3, NONE takes an unused slot
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_NONE = 3'b010,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchOp_e;

    typedef enum logic [2:0] {
        S_FETCH, S_FETCH_RELEASE, S_DECODE, S_EXECUTE, S_RETIRE, S_RETIRE_RELEASE
    } coreState_e;

    typedef struct packed {
        logic [31:0] pc;
    } fetch_t;

    typedef struct packed {
        opcode_e     opcode;
        aluOp_e      aluOp;
        branchOp_e   branchOp;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        useImm;     // Operand B from imm
        logic        writesRd;
        logic        illegal;
    } decoded_t;

    typedef struct packed {
        logic [31:0] value;
        logic [31:0] nextPc;
        logic        taken;
    } execResult_t;

    typedef struct packed {
        logic [`RETIRE_COUNT_W-1:0] seq;
        logic [31:0]                pc;
        logic [4:0]                 rd;
        logic [31:0]                rdValue;
        logic                       writesRd;
        logic [31:0]                nextPc;
        logic                       illegal;
    } retire_t;

endpackage

`default_nettype wire

/* logic/instrDecoder.sv */
`default_nettype none

module instrDecoder import rv_pkg::*; (
    input  wire [31:0] instrReg,
    output decoded_t   decoded
);
    logic [6:0]  opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] immI;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] immU;
    logic        legal;
    logic        writes;

    assign opc    = instrReg[6:0];
    assign funct3 = instrReg[14:12];
    assign funct7 = instrReg[31:25];

    assign immI = {{20{instrReg[31]}}, instrReg[31:20]};
    assign immB = {{19{instrReg[31]}}, instrReg[31], instrReg[7], instrReg[30:25],
                   instrReg[11:8], 1'b0};
    assign immJ = {{11{instrReg[31]}}, instrReg[31], instrReg[19:12], instrReg[20],
                   instrReg[30:21], 1'b0};
    assign immU = {instrReg[31:12], 12'b0};

    always_comb begin
        decoded.aluOp    = ALU_ADD;
        decoded.branchOp = BR_NONE;
        decoded.rs1      = instrReg[19:15];
        decoded.rs2      = instrReg[24:20];
        decoded.rd       = instrReg[11:7];
        decoded.imm      = immI;
        decoded.useImm   = 1'b0;
        legal            = 1'b0;
        writes           = 1'b0;

        case (opc)
            OPC_OP: begin
                writes = 1'b1;
                if (funct7 == 7'b0000000) begin
                    legal = 1'b1;
                    case (funct3)
                        3'b000:  decoded.aluOp = ALU_ADD;
                        3'b001:  decoded.aluOp = ALU_SLL;
                        3'b010:  decoded.aluOp = ALU_SLT;
                        3'b011:  decoded.aluOp = ALU_SLTU;
                        3'b100:  decoded.aluOp = ALU_XOR;
                        3'b101:  decoded.aluOp = ALU_SRL;
                        3'b110:  decoded.aluOp = ALU_OR;
                        default: decoded.aluOp = ALU_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    legal         = (funct3 == 3'b000) || (funct3 == 3'b101);
                    decoded.aluOp = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
                end
            end
            OPC_OP_IMM: begin
                writes         = 1'b1;
                legal          = 1'b1;
                decoded.useImm = 1'b1;
                case (funct3)
                    3'b000: decoded.aluOp = ALU_ADD;
                    3'b010: decoded.aluOp = ALU_SLT;
                    3'b011: decoded.aluOp = ALU_SLTU;
                    3'b100: decoded.aluOp = ALU_XOR;
                    3'b110: decoded.aluOp = ALU_OR;
                    3'b111: decoded.aluOp = ALU_AND;
                    3'b001: begin
                        decoded.aluOp = ALU_SLL;
                        legal         = (funct7 == 7'b0000000);
                    end
                    default: begin
                        decoded.aluOp = funct7[5] ? ALU_SRA : ALU_SRL;    // Bit 30 picks SRAI
                        legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                endcase
            end
            OPC_BRANCH: begin
                decoded.imm      = immB;
                legal            = (funct3 != 3'b010) && (funct3 != 3'b011);
                decoded.branchOp = branchOp_e'(funct3);
            end
            OPC_JAL: begin
                decoded.imm = immJ;
                legal       = 1'b1;
                writes      = 1'b1;
            end
            OPC_JALR: begin
                decoded.useImm = 1'b1;    // ALU forms rs1 + imm
                legal          = (funct3 == 3'b000);
                writes         = 1'b1;
            end
            OPC_LUI: begin
                decoded.imm    = immU;
                decoded.aluOp  = ALU_PASS_B;
                decoded.useImm = 1'b1;
                legal          = 1'b1;
                writes         = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        decoded.opcode   = legal ? opcode_e'(opc) : OPC_ILLEGAL;
        decoded.writesRd = legal && writes;
        decoded.illegal  = !legal;
    end

endmodule

`default_nettype wire

/* logic/aluExecute.sv */
`default_nettype none

module aluExecute import rv_pkg::*; (
    input  wire decoded_t decoded,
    input  wire [31:0]    rs1Value,
    input  wire [31:0]    rs2Value,
    input  wire [31:0]    pc,
    output execResult_t   result
);
    logic [31:0] opB;
    logic [4:0]  shamt;
    logic [31:0] aluValue;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic        isEqual;
    logic        lessSigned;
    logic        lessUnsigned;
    logic        branchCond;

    assign opB      = decoded.useImm ? decoded.imm : rs2Value;
    assign shamt    = opB[4:0];
    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + decoded.imm;    // Branch and JAL target

    // Branch comparator always works on the two registers
    assign isEqual      = (rs1Value == rs2Value);
    assign lessSigned   = $signed(rs1Value) < $signed(rs2Value);
    assign lessUnsigned = rs1Value < rs2Value;

    always_comb begin
        case (decoded.aluOp)
            ALU_ADD:    aluValue = rs1Value + opB;
            ALU_SUB:    aluValue = rs1Value - opB;
            ALU_AND:    aluValue = rs1Value & opB;
            ALU_OR:     aluValue = rs1Value | opB;
            ALU_XOR:    aluValue = rs1Value ^ opB;
            ALU_SLT:    aluValue = {31'b0, $signed(rs1Value) < $signed(opB)};
            ALU_SLTU:   aluValue = {31'b0, rs1Value < opB};
            ALU_SLL:    aluValue = rs1Value << shamt;
            ALU_SRL:    aluValue = rs1Value >> shamt;
            ALU_SRA:    aluValue = $unsigned($signed(rs1Value) >>> shamt);
            ALU_PASS_B: aluValue = opB;
            default:    aluValue = '0;
        endcase
    end

    always_comb begin
        case (decoded.branchOp)
            BR_BEQ:  branchCond = isEqual;
            BR_BNE:  branchCond = !isEqual;
            BR_BLT:  branchCond = lessSigned;
            BR_BGE:  branchCond = !lessSigned;
            BR_BLTU: branchCond = lessUnsigned;
            BR_BGEU: branchCond = !lessUnsigned;
            default: branchCond = 1'b0;
        endcase
    end

    always_comb begin
        result.value  = aluValue;
        result.nextPc = pcPlus4;
        result.taken  = 1'b0;
        case (decoded.opcode)
            OPC_BRANCH: begin
                result.taken  = branchCond;
                result.nextPc = branchCond ? pcTarget : pcPlus4;
            end
            OPC_JAL: begin
                result.value  = pcPlus4;    // Link
                result.nextPc = pcTarget;
                result.taken  = 1'b1;
            end
            OPC_JALR: begin
                result.value  = pcPlus4;
                result.nextPc = {aluValue[31:1], 1'b0};
                result.taken  = 1'b1;
            end
            default: result.taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/resultWriter.sv */
`include "rv_settings.svh"

`default_nettype none

module resultWriter import rv_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        commit,
    input  wire decoded_t    decoded,
    input  wire execResult_t exec,
    input  wire [31:0]       pc,
    output logic [31:0]      rs1Value,
    output logic [31:0]      rs2Value,
    output retire_t          retire
);
    logic [31:0]                regs [`REG_COUNT];
    logic [`RETIRE_COUNT_W-1:0] seq;

    // x0 is cleared by reset and never written
    assign rs1Value = regs[decoded.rs1];
    assign rs2Value = regs[decoded.rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && decoded.writesRd && (decoded.rd != 5'd0)) begin
            regs[decoded.rd] <= exec.value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            seq <= '0;
        end else if (commit) begin
            seq <= seq + 1'b1;    // One step per retire
        end
    end

    // Sources stay put from EXECUTE until commit, so the record is steady under retireReq
    always_comb begin
        retire.seq      = seq;
        retire.pc       = pc;
        retire.rd       = decoded.rd;
        retire.rdValue  = decoded.writesRd ? exec.value : 32'd0;
        retire.writesRd = decoded.writesRd;
        retire.nextPc   = exec.nextPc;
        retire.illegal  = decoded.illegal;
    end

endmodule

`default_nettype wire

/* logic/coreSequencer.sv */
`include "rv_settings.svh"

`default_nettype none

module coreSequencer import rv_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        fetchAck,
    input  wire [31:0]       instr,
    input  wire logic        retireAck,
    output logic             fetchReq,
    output fetch_t           fetch,
    output logic             retireReq,
    input  wire decoded_t    decodedIn,
    output decoded_t         decodedReg,
    input  wire execResult_t execIn,
    output execResult_t      execReg,
    output logic [31:0]      pc,
    output logic [31:0]      instrReg,
    output logic             commit
);
    coreState_e state;
    logic       fetchDone;

    assign fetchDone = (state == S_FETCH) && fetchReq && fetchAck;
    assign fetch     = fetch_t'{pc: pc};
    assign commit    = (state == S_RETIRE) && retireAck;    // Retire handshake done

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_FETCH;
            fetchReq  <= 1'b0;
            retireReq <= 1'b0;
            pc        <= `RESET_PC;
        end else begin
            case (state)
                S_FETCH: begin
                    if (fetchDone) begin
                        fetchReq <= 1'b0;
                        state    <= S_FETCH_RELEASE;
                    end else if (!fetchAck) begin
                        fetchReq <= 1'b1;    // First request after reset
                    end
                end
                S_FETCH_RELEASE: begin
                    if (!fetchAck) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    retireReq <= 1'b1;
                    state     <= S_RETIRE;
                end
                S_RETIRE: begin
                    if (retireAck) begin
                        retireReq <= 1'b0;
                        pc        <= execReg.nextPc;
                        state     <= S_RETIRE_RELEASE;
                    end
                end
                S_RETIRE_RELEASE: begin
                    if (!retireAck) begin
                        fetchReq <= 1'b1;    // Next fetch, ack already low
                        state    <= S_FETCH;
                    end
                end
                default: begin
                    fetchReq  <= 1'b0;
                    retireReq <= 1'b0;
                    state     <= S_FETCH;
                end
            endcase
        end
    end

    // Stage registers
    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instrReg <= instr;
        end
        if (state == S_DECODE) begin
            decodedReg <= decodedIn;
        end
        if (state == S_EXECUTE) begin
            execReg <= execIn;
        end
    end

endmodule

`default_nettype wire

/* logic/rvCore.sv */
`default_nettype none

module rvCore import rv_pkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    output logic       fetchReq,
    output fetch_t     fetch,
    input  wire logic  fetchAck,
    input  wire [31:0] instr,
    output logic       retireReq,
    output retire_t    retire,
    input  wire logic  retireAck
);
    decoded_t    decodedNow;
    decoded_t    decodedReg;
    execResult_t execNow;
    execResult_t execReg;
    logic [31:0] pc;
    logic [31:0] instrReg;
    logic [31:0] rs1Value;
    logic [31:0] rs2Value;
    logic        commit;

    coreSequencer u_coreSequencer (
        .clk        (clk),
        .reset      (reset),
        .fetchAck   (fetchAck),
        .instr      (instr),
        .retireAck  (retireAck),
        .fetchReq   (fetchReq),
        .fetch      (fetch),
        .retireReq  (retireReq),
        .decodedIn  (decodedNow),
        .decodedReg (decodedReg),
        .execIn     (execNow),
        .execReg    (execReg),
        .pc         (pc),
        .instrReg   (instrReg),
        .commit     (commit)
    );

    instrDecoder u_instrDecoder (
        .instrReg (instrReg),
        .decoded  (decodedNow)
    );

    aluExecute u_aluExecute (
        .decoded  (decodedReg),
        .rs1Value (rs1Value),
        .rs2Value (rs2Value),
        .pc       (pc),
        .result   (execNow)
    );

    resultWriter u_resultWriter (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .decoded  (decodedReg),
        .exec     (execReg),
        .pc       (pc),
        .rs1Value (rs1Value),
        .rs2Value (rs2Value),
        .retire   (retire)
    );

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tests/rvCore_props.sv */
`default_nettype none

module rvCore_props import rv_pkg::*; (
    input wire logic    clk,
    input wire logic    reset,
    input wire logic    fetchReq,
    input wire fetch_t  fetch,
    input wire logic    fetchAck,
    input wire logic    retireReq,
    input wire retire_t retire,
    input wire logic    retireAck
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;    // Failures so far

    fetchHold: assert property (@(posedge clk) disable iff (reset)
        fetchReq && !fetchAck |=> fetchReq && $stable(fetch))
        else begin
            failCount++;
            $error("fetchReq dropped or fetch changed before fetchAck");
        end

    retireHold: assert property (@(posedge clk) disable iff (reset)
        retireReq && !retireAck |=> retireReq && $stable(retire))
        else begin
            failCount++;
            $error("retireReq dropped or retire changed before retireAck");
        end

    fetchRise: assert property (@(posedge clk) disable iff (reset)
        $rose(fetchReq) |-> !fetchAck)
        else begin
            failCount++;
            $error("fetchReq rose while fetchAck was high");
        end

    retireRise: assert property (@(posedge clk) disable iff (reset)
        $rose(retireReq) |-> !retireAck)
        else begin
            failCount++;
            $error("retireReq rose while retireAck was high");
        end

    // One instruction in flight
    oneReq: assert property (@(posedge clk) disable iff (reset)
        !(fetchReq && retireReq))
        else begin
            failCount++;
            $error("fetchReq and retireReq high together");
        end

endmodule

bind rvCore rvCore_props u_rvCore_props (
    .clk       (clk),
    .reset     (reset),
    .fetchReq  (fetchReq),
    .fetch     (fetch),
    .fetchAck  (fetchAck),
    .retireReq (retireReq),
    .retire    (retire),
    .retireAck (retireAck)
);

`default_nettype wire

/* tests/rvCore_tb.sv */
`include "rv_settings.svh"

`default_nettype none

module rvCore_tb import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MaxSteps = 64;
    localparam int Fields   = 7;
    // Columns of one data entry
    localparam int ColPc       = 0;
    localparam int ColInstr    = 1;
    localparam int ColRd       = 2;
    localparam int ColRdValue  = 3;
    localparam int ColWritesRd = 4;
    localparam int ColNextPc   = 5;
    localparam int ColIllegal  = 6;

    logic        clk;
    logic        reset;
    logic        fetchReq;
    fetch_t      fetch;
    logic        fetchAck  = 1'b0;
    logic [31:0] instr     = 32'd0;
    logic        retireReq;
    retire_t     retire;
    logic        retireAck = 1'b0;

    logic [31:0] testData [MaxSteps*Fields];
    int          stepCount    = 0;
    int          fetchIdx     = 0;
    int          retireIdx    = 0;
    int          errors       = 0;
    int          fetchDelay   = -1;
    int          retireDelay  = -1;
    logic        resetChecked = 1'b0;
    logic [31:0] rngState     = 32'h7dc81e96;

    clockGen u_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    rvCore u_rvCore (
        .clk       (clk),
        .reset     (reset),
        .fetchReq  (fetchReq),
        .fetch     (fetch),
        .fetchAck  (fetchAck),
        .instr     (instr),
        .retireReq (retireReq),
        .retire    (retire),
        .retireAck (retireAck)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Ack delay of 0 to 3 cycles
    function automatic int nextDelay();
        rngState = xorshift(rngState);
        return int'(rngState[1:0]);
    endfunction

    function automatic logic [31:0] stepField(input int step, input int col);
        return testData[step*Fields + col];
    endfunction

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int step);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s step %0d: got %h expected %h", name, step, got, exp);
        end
    endtask

    // Fetch responder
    always @(posedge clk) begin
        if (reset) begin
            fetchAck   <= 1'b0;
            fetchDelay = -1;
        end else begin
            if (!resetChecked) begin
                resetChecked = 1'b1;
                assert (!fetchReq && !retireReq) else begin
                    errors++;
                    $display("A request output was high right after reset");
                end
            end
            if (fetchAck) begin
                if (!fetchReq) begin
                    fetchAck <= 1'b0;
                end
            end else if (fetchReq && fetchIdx < stepCount) begin
                if (fetchDelay < 0) begin
                    fetchDelay = nextDelay();
                end
                if (fetchDelay > 0) begin
                    fetchDelay--;
                end else begin
                    if (fetchIdx == 0) begin
                        checkField("fetch.pc", fetch.pc, `RESET_PC, 0);
                    end
                    checkField("fetch.pc", fetch.pc, stepField(fetchIdx, ColPc), fetchIdx);
                    assert (fetchIdx == retireIdx) else begin
                        errors++;
                        $display("Fetch %0d came before the previous instruction retired",
                                 fetchIdx);
                    end
                    instr      <= stepField(fetchIdx, ColInstr);
                    fetchAck   <= 1'b1;
                    fetchIdx++;
                    fetchDelay = -1;
                end
            end
        end
    end

    // Retire responder
    always @(posedge clk) begin
        if (reset) begin
            retireAck   <= 1'b0;
            retireDelay = -1;
        end else if (retireAck) begin
            if (!retireReq) begin
                retireAck <= 1'b0;
            end
        end else if (retireReq) begin
            if (retireIdx >= stepCount) begin
                errors++;
                $display("Retire request after the last program step");
                retireAck <= 1'b1;
            end else begin
                if (retireDelay < 0) begin
                    retireDelay = nextDelay();
                end
                if (retireDelay > 0) begin
                    retireDelay--;
                end else begin
                    checkField("retire.seq", 32'(retire.seq),
                               32'(`RETIRE_COUNT_W'(retireIdx)), retireIdx);
                    checkField("retire.pc", retire.pc, stepField(retireIdx, ColPc), retireIdx);
                    checkField("retire.rd", 32'(retire.rd), stepField(retireIdx, ColRd),
                               retireIdx);
                    checkField("retire.rdValue", retire.rdValue,
                               stepField(retireIdx, ColRdValue), retireIdx);
                    checkField("retire.writesRd", 32'(retire.writesRd),
                               stepField(retireIdx, ColWritesRd), retireIdx);
                    checkField("retire.nextPc", retire.nextPc,
                               stepField(retireIdx, ColNextPc), retireIdx);
                    checkField("retire.illegal", 32'(retire.illegal),
                               stepField(retireIdx, ColIllegal), retireIdx);
                    retireAck   <= 1'b1;
                    retireIdx++;
                    retireDelay = -1;
                end
            end
        end
    end

    initial begin
        for (int i = 0; i < MaxSteps*Fields; i++) begin
            testData[i] = 32'hBAD0_0000 | 32'(i);    // Marks unused entries
        end
        $readmemh("tests/rvCore_testdata.txt", testData);
        while (stepCount < MaxSteps &&
               testData[stepCount*Fields] != (32'hBAD0_0000 | 32'(stepCount*Fields))) begin
            stepCount++;
        end
        wait (stepCount > 0 && retireIdx == stepCount);
        repeat (4) @(posedge clk);
        $display("Errors: %0d, handshake assertion failures %0d, retired %0d of %0d steps",
                 errors, u_rvCore.u_rvCore_props.failCount, retireIdx, stepCount);
        if (errors == 0 && u_rvCore.u_rvCore_props.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, about 12 cycles per step plus slack for ack delays
    initial begin
        #1;
        #((stepCount*12 + 400) * 40);
        $display("Timeout: only %0d of %0d steps retired", retireIdx, stepCount);
        $display("Errors: %0d", errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rvCore_testdata.txt */
// pc instr rd rdValue writesRd nextPc illegal, one retire per line in program order
// rdValue is 0 when writesRd is clear
00000000 FFB00093 01 FFFFFFFB 1 00000004 0
00000004 00300113 02 00000003 1 00000008 0
00000008 002081B3 03 FFFFFFFE 1 0000000C 0
0000000C 40110233 04 00000008 1 00000010 0
00000010 0020F2B3 05 00000003 1 00000014 0
00000014 0020E333 06 FFFFFFFB 1 00000018 0
00000018 0020C3B3 07 FFFFFFF8 1 0000001C 0
0000001C 0020A433 08 00000001 1 00000020 0
00000020 0020B4B3 09 00000000 1 00000024 0
00000024 00211533 0A 00000018 1 00000028 0
00000028 0020D5B3 0B 1FFFFFFF 1 0000002C 0
0000002C 4020D633 0C FFFFFFFF 1 00000030 0
00000030 0F00F693 0D 000000F0 1 00000034 0
00000034 FF016713 0E FFFFFFF3 1 00000038 0
00000038 7FF0C793 0F FFFFF804 1 0000003C 0
0000003C FFC0A813 10 00000001 1 00000040 0
00000040 FFF13893 11 00000001 1 00000044 0
00000044 01E11913 12 C0000000 1 00000048 0
00000048 00495993 13 0C000000 1 0000004C 0
0000004C 40495A13 14 FC000000 1 00000050 0
00000050 00210463 08 00000000 0 00000058 0
00000058 00211463 08 00000000 0 0000005C 0
0000005C 0020C463 08 00000000 0 00000064 0
00000064 0020D463 08 00000000 0 00000068 0
00000068 0020E463 08 00000000 0 0000006C 0
0000006C 0020F463 08 00000000 0 00000074 0
00000074 00209463 08 00000000 0 0000007C 0
0000007C 00208463 08 00000000 0 00000080 0
00000080 00114463 08 00000000 0 00000084 0
00000084 00115463 08 00000000 0 0000008C 0
0000008C 00116463 08 00000000 0 00000094 0
00000094 00117463 08 00000000 0 00000098 0
00000098 00C00AEF 15 0000009C 1 000000A4 0
000000A4 12345B37 16 12345000 1 000000A8 0
000000A8 0B900B93 17 000000B9 1 000000AC 0
000000AC 000B8C67 18 000000B0 1 000000B8 0
000000B8 00708013 00 00000002 1 000000BC 0
000000BC 00200CB3 19 00000003 1 000000C0 0
000000C0 00000000 00 00000000 0 000000C4 1
000000C4 0000A003 00 00000000 0 000000C8 1
000000C8 015C8D33 1A 0000009F 1 000000CC 0

/* list.f */
+incdir+logic
logic/rv_pkg.sv
logic/instrDecoder.sv
logic/aluExecute.sv
logic/resultWriter.sv
logic/coreSequencer.sv
logic/rvCore.sv
tests/clockGen.sv
tests/rvCore_props.sv
tests/rvCore_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = rvCore_tb
FILELIST = list.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
